// File: logic/io_bridge.sv
// IO bridge from core IO accesses to the GCI bus
// Word alignment check with fault return
// Write acknowledge one cycle after GCI accept, read return from GCI
`timescale 1ns/100ps
`default_nettype none

module io_bridge (
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Core IO request
	input wire io_req,
	output logic io_busy,
	input wire mist_bus_pkg::access_order_t io_order,
	input wire io_rw,
	input wire [mist_bus_pkg::ADDR_W-1:0] io_addr,
	input wire [mist_bus_pkg::DATA_W-1:0] io_wdata,
	// Core IO return
	output logic io_valid,
	output logic io_fault,
	output logic [mist_bus_pkg::DATA_W-1:0] io_rdata,
	// GCI request
	output logic gci_req,
	input wire gci_busy,
	output logic gci_rw,
	output logic [mist_bus_pkg::ADDR_W-1:0] gci_addr,
	output logic [mist_bus_pkg::DATA_W-1:0] gci_data,
	// GCI return
	input wire gci_ret_valid,
	output logic gci_ret_busy,
	input wire [mist_bus_pkg::DATA_W-1:0] gci_ret_data
);
	import mist_bus_pkg::*;

	io_state_t state_q;
	logic fault_q;
	// Registered access
	logic rw_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;
	logic gci_accept;

	assign gci_accept = gci_req && !gci_busy;

	// Access FSM
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= IO_IDLE;
			fault_q <= 1'b0;
		end else begin
			case (state_q)
				IO_IDLE: begin
					if (io_req) begin
						// Only word accesses reach GCI
						fault_q <= (io_order != ORDER_WORD);
						if (io_order != ORDER_WORD) begin
							state_q <= IO_ACK;
						end else begin
							state_q <= IO_ISSUE;
						end
					end
				end
				IO_ISSUE: begin
					if (gci_accept) begin
						// Write acked right away, read waits for GCI
						state_q <= rw_q ? IO_ACK : IO_WAIT_READ;
					end
				end
				IO_WAIT_READ: begin
					if (gci_ret_valid) begin
						state_q <= IO_ACK;
					end
				end
				default: begin
					state_q <= IO_IDLE;
				end
			endcase
		end
	end

	// Access fields and read data
	always_ff @(posedge iBUS_CLOCK) begin
		if ((state_q == IO_IDLE) && io_req) begin
			rw_q <= io_rw;
			addr_q <= io_addr;
			wdata_q <= io_wdata;
		end
		if ((state_q == IO_WAIT_READ) && gci_ret_valid) begin
			rdata_q <= gci_ret_data;
		end
	end

	// Busy from accept through the ack cycle
	assign io_busy = (state_q != IO_IDLE);
	assign io_valid = (state_q == IO_ACK);
	assign io_fault = (state_q == IO_ACK) && fault_q;
	assign io_rdata = rdata_q;

	// GCI request side
	assign gci_req = (state_q == IO_ISSUE);
	assign gci_rw = rw_q;
	assign gci_addr = addr_q;
	assign gci_data = wdata_q;

	// No new return taken while the last one goes to the core
	assign gci_ret_busy = (state_q == IO_ACK);

endmodule

`default_nettype wire

// File: logic/memory_pipe_arbiter.sv
// Memory pipe arbiter
// Merges instruction fetch and data requests onto one memory bus
// Data wins a tie, one transaction outstanding at a time
// Return line is steered back to the recorded owner
`timescale 1ns/100ps
`default_nettype none

module memory_pipe_arbiter (
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Instruction request
	input wire inst_req,
	output logic inst_lock,
	input wire [mist_bus_pkg::ADDR_W-1:0] inst_addr,
	// Instruction return
	output logic inst_valid,
	input wire inst_busy,
	output logic [mist_bus_pkg::LINE_W-1:0] inst_data,
	// Data request
	input wire data_req,
	output logic data_lock,
	input wire mist_bus_pkg::access_order_t data_order,
	input wire data_rw,
	input wire [mist_bus_pkg::ADDR_W-1:0] data_addr,
	input wire [mist_bus_pkg::DATA_W-1:0] data_wdata,
	// Data return
	output logic data_valid,
	output logic [mist_bus_pkg::DATA_W-1:0] data_rdata,
	// Memory request
	output logic memory_req,
	input wire memory_lock,
	output mist_bus_pkg::access_order_t memory_order,
	output logic memory_rw,
	output logic [mist_bus_pkg::ADDR_W-1:0] memory_addr,
	output logic [mist_bus_pkg::DATA_W-1:0] memory_data,
	// Memory return
	input wire memory_valid,
	output logic memory_busy,
	input wire [mist_bus_pkg::LINE_W-1:0] memory_rdata
);
	import mist_bus_pkg::*;

	arb_state_t state_q;
	requester_t owner_q;
	// Registered fields of the granted request
	access_order_t order_q;
	logic rw_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	// Captured return line
	logic [LINE_W-1:0] line_q;
	logic inst_valid_q;
	logic data_valid_q;
	logic memory_accept;
	logic return_accept;

	// Memory takes the request
	assign memory_accept = memory_req && !memory_lock;
	// Return is only taken while the owner is not stalling
	assign return_accept = (state_q == ARB_WAIT) && memory_valid && !memory_busy;

	// Grant and transaction FSM
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= ARB_IDLE;
			owner_q <= REQ_INST;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					// Data side first
					if (data_req) begin
						state_q <= ARB_ISSUE;
						owner_q <= REQ_DATA;
					end else if (inst_req) begin
						state_q <= ARB_ISSUE;
						owner_q <= REQ_INST;
					end
				end
				ARB_ISSUE: begin
					if (memory_accept) begin
						state_q <= ARB_WAIT;
					end
				end
				ARB_WAIT: begin
					// Writes are acknowledged by memory_valid as well
					if (return_accept) begin
						state_q <= ARB_IDLE;
					end
				end
				default: begin
					state_q <= ARB_IDLE;
				end
			endcase
		end
	end

	// Request fields and return line
	always_ff @(posedge iBUS_CLOCK) begin
		if (state_q == ARB_IDLE) begin
			if (data_req) begin
				order_q <= data_order;
				rw_q <= data_rw;
				addr_q <= data_addr;
				wdata_q <= data_wdata;
			end else if (inst_req) begin
				// Fetch is always a word read
				order_q <= ORDER_WORD;
				rw_q <= 1'b0;
				addr_q <= inst_addr;
				wdata_q <= '0;
			end
		end
		if (return_accept) begin
			line_q <= memory_rdata;
		end
	end

	// One-cycle return pulse to the owner
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			inst_valid_q <= 1'b0;
			data_valid_q <= 1'b0;
		end else begin
			inst_valid_q <= return_accept && (owner_q == REQ_INST);
			data_valid_q <= return_accept && (owner_q == REQ_DATA);
		end
	end

	// Locks held while a transaction is open
	assign data_lock = (state_q != ARB_IDLE);
	// Fetch also blocked in the cycle data wins the grant
	assign inst_lock = (state_q != ARB_IDLE) || data_req;

	// Memory request side
	assign memory_req = (state_q == ARB_ISSUE);
	assign memory_order = order_q;
	assign memory_rw = rw_q;
	assign memory_addr = addr_q;
	assign memory_data = wdata_q;

	// Stall only from the fetch side
	assign memory_busy = (state_q == ARB_WAIT) && (owner_q == REQ_INST) && inst_busy;

	// Returns
	assign inst_valid = inst_valid_q;
	assign inst_data = line_q;
	assign data_valid = data_valid_q;
	// Data word sits in the low half of the line
	assign data_rdata = line_q[DATA_W-1:0];

endmodule

`default_nettype wire

// File: logic/mist_bus_fabric.sv
// Bus fabric top level
// Memory pipe arbiter for fetch and data traffic
// IO bridge for core IO to the GCI bus
`timescale 1ns/100ps
`default_nettype none

module mist_bus_fabric (
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Instruction side
	input wire inst_req,
	output logic inst_lock,
	input wire [mist_bus_pkg::ADDR_W-1:0] inst_addr,
	output logic inst_valid,
	input wire inst_busy,
	output logic [mist_bus_pkg::LINE_W-1:0] inst_data,
	// Data side
	input wire data_req,
	output logic data_lock,
	input wire mist_bus_pkg::access_order_t data_order,
	input wire data_rw,
	input wire [mist_bus_pkg::ADDR_W-1:0] data_addr,
	input wire [mist_bus_pkg::DATA_W-1:0] data_wdata,
	output logic data_valid,
	output logic [mist_bus_pkg::DATA_W-1:0] data_rdata,
	// External memory bus
	output logic memory_req,
	input wire memory_lock,
	output mist_bus_pkg::access_order_t memory_order,
	output logic memory_rw,
	output logic [mist_bus_pkg::ADDR_W-1:0] memory_addr,
	output logic [mist_bus_pkg::DATA_W-1:0] memory_data,
	input wire memory_valid,
	output logic memory_busy,
	input wire [mist_bus_pkg::LINE_W-1:0] memory_rdata,
	// Core IO side
	input wire io_req,
	output logic io_busy,
	input wire mist_bus_pkg::access_order_t io_order,
	input wire io_rw,
	input wire [mist_bus_pkg::ADDR_W-1:0] io_addr,
	input wire [mist_bus_pkg::DATA_W-1:0] io_wdata,
	output logic io_valid,
	output logic io_fault,
	output logic [mist_bus_pkg::DATA_W-1:0] io_rdata,
	// GCI bus
	output logic gci_req,
	input wire gci_busy,
	output logic gci_rw,
	output logic [mist_bus_pkg::ADDR_W-1:0] gci_addr,
	output logic [mist_bus_pkg::DATA_W-1:0] gci_data,
	input wire gci_ret_valid,
	output logic gci_ret_busy,
	input wire [mist_bus_pkg::DATA_W-1:0] gci_ret_data
);

	// Memory interface, ports share the top level names
	memory_pipe_arbiter memory_pipe_arbiter_inst (.*);

	// IO interface
	io_bridge io_bridge_inst (.*);

endmodule

`default_nettype wire

// File: logic/mist_bus_pkg.sv
// Shared definitions of the bus fabric
// Bus widths, access order encoding
// Arbiter, owner and IO bridge state enums
`default_nettype none

package mist_bus_pkg;

	// Address and word widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// Memory return carries two words
	localparam int LINE_W = 64;

	// Access size, same code as the core order field
	typedef enum logic [1:0] {
		ORDER_BYTE = 2'b00,
		ORDER_HALF = 2'b01,
		ORDER_WORD = 2'b10,
		ORDER_NONE = 2'b11
	} access_order_t;

	// Memory pipe arbiter FSM
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ISSUE,
		ARB_WAIT
	} arb_state_t;

	// Owner of the outstanding memory transaction
	typedef enum logic {
		REQ_INST,
		REQ_DATA
	} requester_t;

	// IO bridge FSM
	typedef enum logic [1:0] {
		IO_IDLE,
		IO_ISSUE,
		IO_WAIT_READ,
		IO_ACK
	} io_state_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the bus fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module bus_fabric_tb \
	-f src.f --Mdir obj_dir -o bus_fabric_sim
./obj_dir/bus_fabric_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

// File: src.f
logic/mist_bus_pkg.sv
logic/memory_pipe_arbiter.sv
logic/io_bridge.sv
logic/mist_bus_fabric.sv
tb/memory_model.sv
tb/bus_fabric_tb.sv

// File: tb/bus_fabric_tb.sv
// Testbench top for the bus fabric
// Clock, reset, fetch, data and IO stimulus
// Shadow store reference, return checker, timeout and report
`timescale 1ns/100ps
`default_nettype none

module bus_fabric_tb;
	import mist_bus_pkg::*;

	// 60 accesses over all tests
	localparam int NUM_ACCESSES = 60;
	localparam int TIMEOUT_CYCLES = 30 * NUM_ACCESSES + 10;

	logic iBUS_CLOCK = 1'b0;
	logic inRESET;
	logic inst_req, inst_lock, inst_valid, inst_busy;
	logic [ADDR_W-1:0] inst_addr;
	logic [LINE_W-1:0] inst_data;
	logic data_req, data_lock, data_rw, data_valid;
	access_order_t data_order;
	logic [ADDR_W-1:0] data_addr;
	logic [DATA_W-1:0] data_wdata, data_rdata;
	logic memory_req, memory_lock, memory_rw, memory_valid, memory_busy;
	access_order_t memory_order;
	logic [ADDR_W-1:0] memory_addr;
	logic [DATA_W-1:0] memory_data;
	logic [LINE_W-1:0] memory_rdata;
	logic io_req, io_busy, io_rw, io_valid, io_fault;
	access_order_t io_order;
	logic [ADDR_W-1:0] io_addr;
	logic [DATA_W-1:0] io_wdata, io_rdata;
	logic gci_req, gci_busy, gci_rw, gci_ret_valid, gci_ret_busy;
	logic [ADDR_W-1:0] gci_addr;
	logic [DATA_W-1:0] gci_data, gci_ret_data;

	// Expected returns in issue order
	logic [63:0] exp_inst_q[$];
	logic [63:0] exp_data_q[$];
	logic exp_data_chk_q[$];
	logic [31:0] shadow [logic [31:0]];
	string test_name;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errors_start = 0;
	int ret_seq = 0;
	int last_inst_seq = 0;
	int last_data_seq = 0;
	int cycles = 0;
	logic stall_enable = 1'b0;
	integer seed = 32'h4141_e840;
	integer stall_seed = 32'h4141_e840;

	mist_bus_fabric mist_bus_fabric_inst (.*);
	memory_model memory_model_inst (.*);

	always #10 iBUS_CLOCK = ~iBUS_CLOCK;

	// Reference words from the shadow store
	function automatic logic [31:0] ref_word(input logic [31:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ 32'hA5A5_A5A5;
	endfunction

	function automatic logic [63:0] ref_line(input logic [31:0] a);
		return {ref_word(a + 32'd4), ref_word(a)};
	endfunction

	// GCI responder read rule
	function automatic logic [31:0] gci_read_value(input logic [31:0] a);
		return a ^ 32'h3C3C_0F0F;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Compare returns against the expected queues
	always @(posedge iBUS_CLOCK) begin : compare_returns
		logic [63:0] exp;
		logic chk;
		// Fetches and data accesses are all word accesses
		if (memory_req && !memory_lock) begin
			check_value({test_name, " memory order"}, 64'(ORDER_WORD), 64'(memory_order));
		end
		if (inst_valid) begin
			ret_seq++;
			last_inst_seq = ret_seq;
			if (exp_inst_q.size() == 0) begin
				errors++;
				$display("%s: instruction return with no fetch outstanding", test_name);
			end else begin
				exp = exp_inst_q.pop_front();
				check_value({test_name, " fetch line"}, exp, inst_data);
			end
		end
		if (data_valid) begin
			ret_seq++;
			last_data_seq = ret_seq;
			if (exp_data_q.size() == 0) begin
				errors++;
				$display("%s: data return with no data access outstanding", test_name);
			end else begin
				exp = exp_data_q.pop_front();
				chk = exp_data_chk_q.pop_front();
				if (chk) begin
					check_value({test_name, " data read"}, exp, 64'(data_rdata));
				end
			end
		end
	end

	// Random fetch stall in the stress test
	always @(posedge iBUS_CLOCK) begin : drive_stall
		logic [31:0] rnd;
		#1;
		rnd = $random(stall_seed);
		inst_busy = stall_enable && (rnd[1:0] != 2'b00);
	end

	always @(posedge iBUS_CLOCK) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles in %s, the DUT stopped responding",
				cycles, test_name);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic fetch(input logic [31:0] addr);
		@(posedge iBUS_CLOCK);
		#1;
		inst_req = 1'b1;
		inst_addr = addr;
		do @(posedge iBUS_CLOCK); while (inst_lock);
		exp_inst_q.push_back(ref_line(addr));
		#1 inst_req = 1'b0;
	endtask

	task automatic data_access(input logic rw, input logic [31:0] addr,
		input logic [31:0] wdata);
		@(posedge iBUS_CLOCK);
		#1;
		data_req = 1'b1;
		data_order = ORDER_WORD;
		data_rw = rw;
		data_addr = addr;
		data_wdata = wdata;
		do @(posedge iBUS_CLOCK); while (data_lock);
		// Shadow follows the accept order
		if (rw) begin
			shadow[addr] = wdata;
			exp_data_q.push_back(64'd0);
			exp_data_chk_q.push_back(1'b0);
		end else begin
			exp_data_q.push_back({32'd0, ref_word(addr)});
			exp_data_chk_q.push_back(1'b1);
		end
		#1;
		data_req = 1'b0;
		// Order only valid with the request
		data_order = ORDER_NONE;
	endtask

	// All returns in, or report the missing ones
	task automatic wait_idle();
		int n;
		n = 0;
		while ((exp_inst_q.size() != 0 || exp_data_q.size() != 0) && n < 80) begin
			@(posedge iBUS_CLOCK);
			#1;
			n++;
		end
		if (exp_inst_q.size() != 0 || exp_data_q.size() != 0) begin
			errors++;
			$display("%s: %0d fetch and %0d data returns never arrived", test_name,
				exp_inst_q.size(), exp_data_q.size());
			exp_inst_q.delete();
			exp_data_q.delete();
			exp_data_chk_q.delete();
		end
	endtask

	task automatic io_access(input access_order_t order, input logic rw,
		input logic [31:0] addr, input logic [31:0] wdata);
		int n;
		int accept_at;
		logic seen_gci;
		logic done;
		@(posedge iBUS_CLOCK);
		#1;
		io_req = 1'b1;
		io_order = order;
		io_rw = rw;
		io_addr = addr;
		io_wdata = wdata;
		do @(posedge iBUS_CLOCK); while (io_busy);
		#1 io_req = 1'b0;
		n = 0;
		accept_at = -100;
		seen_gci = 1'b0;
		done = 1'b0;
		while (!done && n < 60) begin
			@(posedge iBUS_CLOCK);
			n++;
			seen_gci = seen_gci || gci_req;
			if (gci_req && !gci_busy) begin
				accept_at = n;
				check_value({test_name, " gci addr"}, 64'(addr), 64'(gci_addr));
				check_value({test_name, " gci rw"}, 64'(rw), 64'(gci_rw));
				if (rw) begin
					check_value({test_name, " gci data"}, 64'(wdata), 64'(gci_data));
				end
			end
			if (io_valid) begin
				done = 1'b1;
				if (order == ORDER_WORD) begin
					check_value({test_name, " io fault"}, 64'd0, 64'(io_fault));
					if (rw) begin
						check_value({test_name, " ack delay"}, 64'd1, 64'(n - accept_at));
					end else begin
						check_value({test_name, " io read"}, 64'(gci_read_value(addr)),
							64'(io_rdata));
					end
				end else begin
					check_value({test_name, " io fault"}, 64'd1, 64'(io_fault));
					check_value({test_name, " gci request"}, 64'd0, 64'(seen_gci));
				end
			end
		end
		if (!done) begin
			errors++;
			$display("%s: IO access at %h never got io_valid", test_name, addr);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_start = errors;
	endtask

	task automatic report_test();
		tests++;
		$display("test %s finished with %0d errors", test_name, errors - test_errors_start);
	endtask

	initial begin : stimulus
		logic [31:0] rnd;
		logic [31:0] addrs [8];
		logic [31:0] words [8];
		inRESET = 1'b0;
		inst_req = 1'b0;
		inst_addr = '0;
		inst_busy = 1'b0;
		data_req = 1'b0;
		data_order = ORDER_NONE;
		data_rw = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		io_req = 1'b0;
		io_order = ORDER_WORD;
		io_rw = 1'b0;
		io_addr = '0;
		io_wdata = '0;
		test_name = "reset";
		repeat (10) @(posedge iBUS_CLOCK);
		#1 inRESET = 1'b1;

		start_test("fetch_default");
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			fetch({rnd[31:2], 2'b00});
		end
		wait_idle();
		report_test();

		// Writes first, then read back the same words
		start_test("data_write_read");
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			addrs[i] = {16'h0002, rnd[15:2], 2'b00};
			words[i] = $random(seed);
			data_access(1'b1, addrs[i], words[i]);
		end
		for (int i = 0; i < 8; i++) begin
			data_access(1'b0, addrs[i], 32'd0);
		end
		wait_idle();
		report_test();

		start_test("data_priority");
		for (int i = 0; i < 4; i++) begin
			addrs[0] = {$random(seed)} & 32'hFFFF_FFFC;
			addrs[1] = {$random(seed)} & 32'hFFFF_FFFC;
			fork
				fetch(addrs[0]);
				data_access(1'b0, addrs[1], 32'd0);
			join
			wait_idle();
			check_value("data_priority order", 64'd1, 64'(last_data_seq < last_inst_seq));
		end
		report_test();

		// Small window so fetches and data overlap
		start_test("stall_stress");
		stall_enable = 1'b1;
		fork
			begin : fetch_thread
				logic [31:0] r;
				for (int i = 0; i < 8; i++) begin
					r = $random(seed);
					fetch(32'h0000_1000 + {26'd0, r[5:2], 2'b00});
				end
			end
			begin : data_thread
				logic [31:0] r;
				for (int i = 0; i < 8; i++) begin
					r = $random(seed);
					data_access(r[8], 32'h0000_1000 + {26'd0, r[5:2], 2'b00}, $random(seed));
				end
			end
		join
		wait_idle();
		stall_enable = 1'b0;
		report_test();

		start_test("io_word");
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			io_access(ORDER_WORD, i[0] == 1'b0, {rnd[31:2], 2'b00}, $random(seed));
		end
		report_test();

		start_test("io_misaligned");
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			io_access(i[0] ? ORDER_HALF : ORDER_BYTE, rnd[0], rnd, $random(seed));
		end
		report_test();

		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/memory_model.sv
// Behavioral responders for the bus fabric testbench
// Memory with sparse word store, random lock and 1 to 6 cycle returns
// GCI target with random busy and delayed read returns
`timescale 1ns/100ps
`default_nettype none

module memory_model (
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Memory bus
	input wire memory_req,
	output logic memory_lock,
	input wire memory_rw,
	input wire [31:0] memory_addr,
	input wire [31:0] memory_data,
	output logic memory_valid,
	input wire memory_busy,
	output logic [63:0] memory_rdata,
	// GCI bus
	input wire gci_req,
	output logic gci_busy,
	input wire gci_rw,
	input wire [31:0] gci_addr,
	output logic gci_ret_valid,
	input wire gci_ret_busy,
	output logic [31:0] gci_ret_data
);

	// Written words only
	logic [31:0] store [logic [31:0]];
	integer mem_seed = 32'h4141_e840;
	integer gci_seed = 32'h4141_e840;

	// Unwritten words follow the address pattern
	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (store.exists(a)) begin
			return store[a];
		end
		return a ^ 32'hA5A5_A5A5;
	endfunction

	// Memory side, one transaction at a time
	initial begin : memory_side
		logic [31:0] rnd;
		logic [31:0] addr;
		logic accepted;
		int delay;
		memory_lock = 1'b0;
		memory_valid = 1'b0;
		memory_rdata = '0;
		addr = '0;
		rnd = '0;
		forever begin
			accepted = 1'b0;
			while (!accepted) begin
				@(posedge iBUS_CLOCK);
				accepted = inRESET && memory_req && !memory_lock;
				if (accepted) begin
					addr = memory_addr;
					if (memory_rw) begin
						store[addr] = memory_data;
					end
				end
				#1;
				rnd = $random(mem_seed);
				memory_lock = (rnd[1:0] == 2'b00);
			end
			delay = 1 + int'(rnd[10:8] % 3'd6);
			repeat (delay - 1) begin
				@(posedge iBUS_CLOCK);
				#1;
			end
			// Fetch line is word at addr low, addr+4 high
			memory_valid = 1'b1;
			memory_rdata = {read_word(addr + 32'd4), read_word(addr)};
			// Held while the arbiter stalls
			do @(posedge iBUS_CLOCK); while (memory_busy);
			#1 memory_valid = 1'b0;
		end
	end

	// GCI side, reads answer with address XOR pattern
	initial begin : gci_side
		logic [31:0] rnd;
		logic [31:0] addr;
		logic accepted;
		logic rw;
		gci_busy = 1'b0;
		gci_ret_valid = 1'b0;
		gci_ret_data = '0;
		forever begin
			accepted = 1'b0;
			while (!accepted) begin
				@(posedge iBUS_CLOCK);
				accepted = inRESET && gci_req && !gci_busy;
				addr = gci_addr;
				rw = gci_rw;
				#1;
				rnd = $random(gci_seed);
				gci_busy = (rnd[1:0] == 2'b00);
			end
			if (!rw) begin
				repeat (int'(rnd[5:4])) begin
					@(posedge iBUS_CLOCK);
					#1;
				end
				gci_ret_valid = 1'b1;
				gci_ret_data = addr ^ 32'h3C3C_0F0F;
				do @(posedge iBUS_CLOCK); while (gci_ret_busy);
				#1 gci_ret_valid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire
